// File: data_mem_stage.f
+incdir+tb
logic/mem_pkg.sv
logic/store_align.sv
logic/data_ram.sv
logic/load_extract.sv
logic/data_mem_stage.sv
tb/data_mem_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the data memory stage testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module data_mem_stage_tb -o data_mem_stage_sim \
    -f data_mem_stage.f \
    && ./obj_dir/data_mem_stage_sim > "$LOG" 2>&1

[ -f "$LOG" ] && cat "$LOG"

grep -q "^Simulation completed successfully$" "$LOG" 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

exit 0

// File: tb/data_mem_stage_checks.svh
`ifndef DATA_MEM_STAGE_CHECKS_SVH
`define DATA_MEM_STAGE_CHECKS_SVH

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic check_load(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH load_data: got 0x%08h, expected 0x%08h", got, exp));
    end
endtask

task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH load_valid: got 0x%0h, expected 0x%0h", got, exp));
    end
endtask

//////////////////////////////////////////////////
// Shadow byte memory
//////////////////////////////////////////////////

// One entry per RAM byte, addressed by {word index, lane}
logic [7:0] shadow_mem [4*mem_pkg::MEM_WORDS];

function automatic logic [7:0] shadow_byte(input logic [31:0] addr, input logic [1:0] lane);
    return shadow_mem[{addr[mem_pkg::WORD_IDX_W+1:2], lane}];
endfunction

function automatic void shadow_write(input mem_pkg::mem_req_t r);
    logic [mem_pkg::WORD_IDX_W-1:0] idx;
    idx = r.addr[mem_pkg::WORD_IDX_W+1:2];             // Upper bits are not decoded
    case (r.width)
        mem_pkg::W_BYTE,
        mem_pkg::W_UBYTE: begin
            shadow_mem[{idx, r.addr[1:0]}] = r.wdata[7:0];
        end
        mem_pkg::W_HALF,
        mem_pkg::W_UHALF: begin
            shadow_mem[{idx, r.addr[1], 1'b0}] = r.wdata[7:0];  // Offset 3 acts as 2
            shadow_mem[{idx, r.addr[1], 1'b1}] = r.wdata[15:8];
        end
        default: begin
            shadow_mem[{idx, 2'd0}] = r.wdata[7:0];
            shadow_mem[{idx, 2'd1}] = r.wdata[15:8];
            shadow_mem[{idx, 2'd2}] = r.wdata[23:16];
            shadow_mem[{idx, 2'd3}] = r.wdata[31:24];
        end
    endcase
endfunction

// Expected load result for a request, by the width and extension rules
function automatic logic [31:0] shadow_read(input mem_pkg::mem_req_t r);
    logic [7:0]  b;
    logic [15:0] h;
    b = shadow_byte(r.addr, r.addr[1:0]);
    h = {shadow_byte(r.addr, {r.addr[1], 1'b1}), shadow_byte(r.addr, {r.addr[1], 1'b0})};
    case (r.width)
        mem_pkg::W_BYTE:  return {{24{b[7]}}, b};
        mem_pkg::W_UBYTE: return {24'h000000, b};
        mem_pkg::W_HALF:  return {{16{h[15]}}, h};
        mem_pkg::W_UHALF: return {16'h0000, h};
        default: begin
            return {shadow_byte(r.addr, 2'd3), shadow_byte(r.addr, 2'd2),
                    shadow_byte(r.addr, 2'd1), shadow_byte(r.addr, 2'd0)};
        end
    endcase
endfunction

`endif

// File: tb/data_mem_stage_tb.sv
`default_nettype none

module data_mem_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;
    localparam int IDLE_REQS    = 8;
    localparam int WORD_REQS    = 13;
    localparam int BYTE_REQS    = 19;
    localparam int HALF_REQS    = 24;
    localparam int RAND_REQS    = 200;
    localparam int MIX_WORDS    = 16;                  // Words the random mix works in
    localparam int MIX_REQS     = MIX_WORDS + RAND_REQS + 1;
    localparam int TOTAL_REQS   = IDLE_REQS + WORD_REQS + BYTE_REQS + HALF_REQS + MIX_REQS;
    localparam int MAX_CYCLES   = 4 * TOTAL_REQS + RESET_CYCLES + 100;
    localparam logic [31:0] MIX_BASE = 32'h0000_0800;  // Word index 0x200

    logic              clk;
    logic              rst_n;
    mem_pkg::mem_req_t req;
    logic              load_valid;
    logic [31:0]       load_data;

    logic              exp_valid;                      // Expected result of the last request
    logic [31:0]       exp_data;
    integer            seed;
    int                cycle_count = 0;

    data_mem_stage data_mem_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

    `include "data_mem_stage_checks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles, tests did not finish", cycle_count));
        end
    end

    //////////////////////////////////////////////////
    // Request helpers
    //////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic mem_pkg::mem_req_t build_req(input mem_pkg::mem_op_e op,
                                                     input mem_pkg::mem_width_e width,
                                                     input logic [31:0] addr,
                                                     input logic [31:0] wdata);
        mem_pkg::mem_req_t r;
        r.op    = op;
        r.width = width;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // Outputs seen at this negedge belong to the request driven one cycle earlier
    task automatic drive_request(input mem_pkg::mem_req_t r);
        @(posedge clk);
        req <= r;
        @(negedge clk);
        check_valid(load_valid, exp_valid);
        check_load(load_data, exp_data);
        exp_valid = (r.op == mem_pkg::MEM_LOAD);
        exp_data  = exp_valid ? shadow_read(r) : 32'h0000_0000;
        if (r.op == mem_pkg::MEM_STORE) begin
            shadow_write(r);
        end
    endtask

    task automatic write_mem(input mem_pkg::mem_width_e w, input logic [31:0] a,
                             input logic [31:0] d);
        drive_request(build_req(mem_pkg::MEM_STORE, w, a, d));
    endtask

    task automatic read_mem(input mem_pkg::mem_width_e w, input logic [31:0] a);
        drive_request(build_req(mem_pkg::MEM_LOAD, w, a, 32'h0));
    endtask

    task automatic idle_cycle();
        drive_request(build_req(mem_pkg::MEM_NONE, mem_pkg::W_WORD, 32'h0, 32'h0));
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic reset_and_idle();
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            // Loads during reset must not raise valid
            req <= build_req(mem_pkg::MEM_LOAD, mem_pkg::W_WORD, 32'h0, 32'h0);
            @(negedge clk);
            check_valid(load_valid, 1'b0);
            check_load(load_data, 32'h0000_0000);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        req   <= build_req(mem_pkg::MEM_NONE, mem_pkg::W_WORD, 32'h0, 32'h0);
        idle_cycle();
        idle_cycle();
        idle_cycle();
        write_mem(mem_pkg::W_WORD, 32'h0000_0040, 32'hCAFE_F00D);
        idle_cycle();
        write_mem(mem_pkg::W_BYTE, 32'h0000_0041, 32'h0000_0099);
        write_mem(mem_pkg::W_HALF, 32'h0000_0042, 32'h0000_7711);
        idle_cycle();
    endtask

    task automatic word_round_trip();
        logic [31:0] addrs [6];
        logic [31:0] words [6];
        addrs = '{32'h0000_0000, 32'h0000_0007, 32'h0000_0556,
                  32'h0000_0FF9, 32'h0000_0FFC, 32'hABC0_1230};
        words = '{32'h1234_5678, 32'h8000_0001, 32'hDEAD_BEEF,
                  32'h0F1E_2D3C, 32'hFFFF_FFFF, 32'hA5C3_3C5A};
        foreach (addrs[i]) begin
            write_mem(mem_pkg::W_WORD, addrs[i], words[i]);
        end
        foreach (addrs[i]) begin
            read_mem(mem_pkg::W_WORD, addrs[i] ^ 32'h3);    // Low bits flipped
        end
        idle_cycle();
    endtask

    task automatic byte_lanes();
        logic [7:0]  bytes [4];
        logic [31:0] base;
        bytes = '{8'h7E, 8'h81, 8'h3C, 8'hF0};
        base  = 32'h0000_0100;
        write_mem(mem_pkg::W_WORD, base, 32'h4433_2211);
        for (int off = 0; off < 4; off++) begin
            write_mem(mem_pkg::W_BYTE, base + off, {24'hC0FFEE, bytes[off]});
            read_mem(mem_pkg::W_WORD, base);
            read_mem(mem_pkg::W_BYTE, base + off);
            read_mem(mem_pkg::W_UBYTE, base + off);
        end
        read_mem(mem_pkg::W_WORD, base + 2);
        idle_cycle();
    endtask

    task automatic read_halves(input logic [31:0] base);
        for (int off = 0; off < 4; off++) begin
            read_mem(mem_pkg::W_HALF, base + off);
            read_mem(mem_pkg::W_UHALF, base + off);
        end
    endtask

    task automatic half_lanes();
        logic [31:0] base;
        base = 32'h0000_0104;
        write_mem(mem_pkg::W_WORD, base, 32'h0F0F_0F0F);
        write_mem(mem_pkg::W_HALF, base, 32'hAAAA_8123);
        write_mem(mem_pkg::W_HALF, base + 3, 32'h5555_7EF5);   // Lands at offset 2
        read_halves(base);
        read_mem(mem_pkg::W_WORD, base);
        write_mem(mem_pkg::W_UHALF, base + 2, 32'h1234_F00D);
        write_mem(mem_pkg::W_HALF, base + 1, 32'h0000_0042);
        read_halves(base);
        read_mem(mem_pkg::W_WORD, base);
        idle_cycle();
    endtask

    task automatic random_mix();
        int unsigned         kind;
        int unsigned         pick;
        logic [31:0]         addr;
        logic [31:0]         data;
        mem_pkg::mem_width_e width;
        seed = 32'h9c33;
        for (int i = 0; i < MIX_WORDS; i++) begin
            data = $random(seed);
            write_mem(mem_pkg::W_WORD, MIX_BASE + 32'(4 * i), data);
        end
        for (int i = 0; i < RAND_REQS; i++) begin
            kind  = $random(seed);
            pick  = $random(seed);
            addr  = $random(seed);
            data  = $random(seed);
            // Random upper bits and offset with the word index kept inside the window
            addr[mem_pkg::WORD_IDX_W+1:2] = MIX_BASE[mem_pkg::WORD_IDX_W+1:2]
                                            + 10'(pick % MIX_WORDS);
            width = mem_pkg::mem_width_e'(3'((pick >> 8) % 5));
            case (kind % 8)
                0, 1, 2: write_mem(width, addr, data);
                7:       idle_cycle();
                default: read_mem(width, addr);
            endcase
        end
        idle_cycle();
    endtask

    initial begin
        rst_n     <= 1'b0;
        req       <= build_req(mem_pkg::MEM_NONE, mem_pkg::W_WORD, 32'h0, 32'h0);
        exp_valid = 1'b0;
        exp_data  = 32'h0000_0000;
        reset_and_idle();
        word_round_trip();
        byte_lanes();
        half_lanes();
        random_mix();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/data_mem_stage.sv
`default_nettype none

module data_mem_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t req,
    output logic              load_valid,
    output logic [31:0]       load_data
);

    mem_pkg::ram_cmd_t  cmd;
    mem_pkg::lane_ctl_t lane_req;   // Lane control at request time
    mem_pkg::lane_ctl_t lane_rd;    // Same, one cycle later with the word
    logic [31:0]        rdata;
    logic               rvalid;

    //////////////////////////////////////////////////
    // Request decode, RAM, result extraction
    //////////////////////////////////////////////////

    store_align store_align_i (
        .req  (req),
        .cmd  (cmd),
        .lane (lane_req)
    );

    data_ram data_ram_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .lane_in  (lane_req),
        .rdata    (rdata),
        .lane_out (lane_rd),
        .rvalid   (rvalid)
    );

    load_extract load_extract_i (
        .rdata      (rdata),
        .lane       (lane_rd),
        .rvalid     (rvalid),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

// File: logic/load_extract.sv
`default_nettype none

module load_extract (
    input  logic [31:0]        rdata,
    input  mem_pkg::lane_ctl_t lane,
    input  logic               rvalid,
    output logic               load_valid,
    output logic [31:0]        load_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] ext_data;

    //////////////////////////////////////////////////
    // Lane selection
    //////////////////////////////////////////////////

    always_comb begin
        case (lane.offset)
            2'd0:    byte_sel = rdata[7:0];
            2'd1:    byte_sel = rdata[15:8];
            2'd2:    byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
    end

    // Offsets 2 and 3 both pick the upper half
    assign half_sel = lane.offset[1] ? rdata[31:16] : rdata[15:0];

    //////////////////////////////////////////////////
    // Sign or zero extension
    //////////////////////////////////////////////////

    always_comb begin
        case (lane.width)
            mem_pkg::W_BYTE: begin
                ext_data = {{24{byte_sel[7]}}, byte_sel};
            end
            mem_pkg::W_UBYTE: begin
                ext_data = {24'h000000, byte_sel};
            end
            mem_pkg::W_HALF: begin
                ext_data = {{16{half_sel[15]}}, half_sel};
            end
            mem_pkg::W_UHALF: begin
                ext_data = {16'h0000, half_sel};
            end
            default: begin
                ext_data = rdata;                   // Whole word
            end
        endcase
    end

    // Idle cycles carry zero instead of the last word read
    assign load_valid = rvalid;
    assign load_data  = rvalid ? ext_data : 32'h0000_0000;

endmodule

`default_nettype wire

// File: logic/data_ram.sv
`default_nettype none

module data_ram (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_pkg::ram_cmd_t  cmd,
    input  mem_pkg::lane_ctl_t lane_in,
    output logic [31:0]        rdata,
    output mem_pkg::lane_ctl_t lane_out,
    output logic               rvalid
);

    logic [31:0] mem [mem_pkg::MEM_WORDS];

    //////////////////////////////////////////////////
    // Byte-lane write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cmd.we) begin
            for (int i = 0; i < 4; i++) begin
                if (cmd.byte_en[i]) begin
                    mem[cmd.word_idx][8*i +: 8] <= cmd.wdata[8*i +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Registered read with its lane control
    //////////////////////////////////////////////////

    // A same-cycle write to this word is not seen here, old data comes out
    always_ff @(posedge clk) begin
        if (cmd.re) begin
            rdata    <= mem[cmd.word_idx];
            lane_out <= lane_in;
        end
    end

    // Valid drops on any cycle without a read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= cmd.re;
        end
    end

endmodule

`default_nettype wire

// File: logic/store_align.sv
`default_nettype none

module store_align (
    input  mem_pkg::mem_req_t  req,
    output mem_pkg::ram_cmd_t  cmd,
    output mem_pkg::lane_ctl_t lane
);

    logic [1:0]                      offset;
    logic [mem_pkg::WORD_IDX_W-1:0] word_idx;
    logic [3:0]                      byte_en;
    logic [31:0]                     lane_data;

    assign offset   = req.addr[1:0];
    assign word_idx = req.addr[mem_pkg::WORD_IDX_W+1:2]; // Upper address bits dropped

    //////////////////////////////////////////////////
    // Lane enables and data steering
    //////////////////////////////////////////////////

    always_comb begin
        byte_en   = 4'b1111;
        lane_data = req.wdata;
        case (req.width)
            mem_pkg::W_BYTE,
            mem_pkg::W_UBYTE: begin
                byte_en   = 4'b0001 << offset;
                lane_data = {4{req.wdata[7:0]}};    // Every lane gets the byte
            end
            mem_pkg::W_HALF,
            mem_pkg::W_UHALF: begin
                // Offset 3 falls back to the upper half, only bit 1 counts
                byte_en   = req.addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{req.wdata[15:0]}};
            end
            mem_pkg::W_WORD: begin
                byte_en   = 4'b1111;
                lane_data = req.wdata;
            end
            default: begin
                byte_en   = 4'b1111;
                lane_data = req.wdata;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // RAM command and load lane control
    //////////////////////////////////////////////////

    always_comb begin
        cmd.we       = 1'b0;
        cmd.re       = 1'b0;
        cmd.byte_en  = 4'b0000;
        cmd.word_idx = word_idx;
        cmd.wdata    = lane_data;
        lane.width   = mem_pkg::W_WORD;
        lane.offset  = 2'b00;

        case (req.op)
            mem_pkg::MEM_STORE: begin
                cmd.we      = 1'b1;
                cmd.byte_en = byte_en;
            end
            mem_pkg::MEM_LOAD: begin
                cmd.re      = 1'b1;
                lane.width  = req.width;            // Needed again at extraction
                lane.offset = offset;
            end
            default: ;                              // Idle, nothing to do
        endcase
    end

endmodule

`default_nettype wire

// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    //////////////////////////////////////////////////
    // RAM geometry
    //////////////////////////////////////////////////

    localparam int MEM_WORDS  = 1024;   // Depth in 32-bit words
    localparam int WORD_IDX_W = 10;     // log2 of MEM_WORDS

    //////////////////////////////////////////////////
    // Request encodings
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,               // Idle cycle
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // Store only looks at the size, unsigned codes map to their signed size
    typedef enum logic [2:0] {
        W_BYTE  = 3'd0,
        W_HALF  = 3'd1,
        W_WORD  = 3'd2,
        W_UBYTE = 3'd3,
        W_UHALF = 3'd4
    } mem_width_e;

    //////////////////////////////////////////////////
    // Structs passed between the stage blocks
    //////////////////////////////////////////////////

    typedef struct packed {
        mem_op_e     op;
        mem_width_e  width;
        logic [31:0] addr;              // Byte address
        logic [31:0] wdata;             // Store data, right aligned
    } mem_req_t;

    typedef struct packed {
        logic                  we;
        logic                  re;
        logic [3:0]            byte_en; // One bit per byte lane
        logic [WORD_IDX_W-1:0] word_idx;
        logic [31:0]           wdata;   // Already placed in its lanes
    } ram_cmd_t;

    // Kept alongside a load until its word comes back
    typedef struct packed {
        mem_width_e width;
        logic [1:0] offset;
    } lane_ctl_t;

endpackage

`default_nettype wire
